//--- verilog/loader_pkg.sv
`default_nettype none

// shared types and constants for the serial program loader
package loader_pkg;

	// ==============================
	// datapath widths
	// ==============================
	typedef logic [7:0]  byte_t;      // one received byte
	typedef logic [31:0] word_t;      // assembled program word
	typedef logic [7:0]  addr_t;      // load memory word address
	typedef logic [15:0] div_t;       // bit period minus one, in clocks
	typedef logic [15:0] cnt_t;       // saturating event count

	// host config bus
	typedef logic [2:0]  reg_addr_t;
	typedef logic [15:0] cfg_data_t;

	// receiver FSM, one state per frame field plus hold
	typedef enum logic [2:0] {
		idle,
		start,
		data,
		parity,
		stop,
		hold     // good byte waiting for handshake
	} rx_state_t;

	// ==============================
	// register map
	// ==============================
	localparam reg_addr_t reg_div   = 3'd0;   // rw
	localparam reg_addr_t reg_base  = 3'd1;   // rw
	localparam reg_addr_t reg_perr  = 3'd2;   // ro
	localparam reg_addr_t reg_ferr  = 3'd3;   // ro
	localparam reg_addr_t reg_ovr   = 3'd4;   // ro
	localparam reg_addr_t reg_words = 3'd5;   // ro

	localparam div_t div_reset = 16'd15;      // 16 clocks per bit out of reset
	localparam int   mem_depth = 256;         // words in load memory

endpackage

`default_nettype wire

//--- verilog/uart_rx.sv
`timescale 1ns/1ps
`default_nettype none

// 8E1 receiver, bit period div+1 clocks, samples mid-bit
module uart_rx (
	input  logic              dec_CLK,
	input  logic              nrst,
	input  logic              rxd,
	input  loader_pkg::div_t  div,
	output logic              byte_valid,
	output loader_pkg::byte_t byte_data,
	input  logic              byte_ready,
	output logic              rx_err,
	output logic              perr_pulse,
	output logic              ferr_pulse,
	output logic              ovr_pulse
);
	import loader_pkg::*;

	logic       rxd_meta;
	logic       rxd_s;        // synchronised line
	rx_state_t  state;
	div_t       bit_cnt;      // clocks left to next sample
	logic [2:0] bit_idx;
	byte_t      shreg;
	logic       par_acc;      // xor of data bits so far
	logic       par_bad;
	logic       skip;         // frame began during hold, gets dropped
	logic       tick;
	logic       take;
	logic       held_next;
	logic       frame_ok;

	assign tick      = (bit_cnt == '0);
	assign take      = byte_valid & byte_ready;
	assign held_next = byte_valid & ~take;   // byte still held after this edge
	// good frame at the stop sample
	assign frame_ok  = (state == stop) & tick & ~skip & ~par_bad & rxd_s;

	// ==============================
	// input synchroniser
	// ==============================
	always_ff @(posedge dec_CLK) begin
		if (nrst) begin
			rxd_meta <= 1'b1;   // line idles high
			rxd_s    <= 1'b1;
		end else begin
			rxd_meta <= rxd;
			rxd_s    <= rxd_meta;
		end
	end

	// ==============================
	// frame FSM
	// ==============================
	always_ff @(posedge dec_CLK) begin
		if (nrst) begin
			state      <= idle;
			bit_cnt    <= '0;
			bit_idx    <= '0;
			par_acc    <= 1'b0;
			par_bad    <= 1'b0;
			skip       <= 1'b0;
			byte_valid <= 1'b0;
			rx_err     <= 1'b0;
			perr_pulse <= 1'b0;
			ferr_pulse <= 1'b0;
			ovr_pulse  <= 1'b0;
		end else begin
			rx_err     <= 1'b0;   // pulses default low
			perr_pulse <= 1'b0;
			ferr_pulse <= 1'b0;
			ovr_pulse  <= 1'b0;
			if (take)
				byte_valid <= 1'b0;
			if (state inside {start, data, parity, stop})
				bit_cnt <= tick ? div : bit_cnt - 1'b1;   // one bit period per sample

			case (state)
				idle: begin
					if (!rxd_s) begin
						state   <= start;
						bit_cnt <= div >> 1;   // half a period to start check
					end
				end
				hold: begin
					if (!rxd_s) begin
						state     <= start;
						bit_cnt   <= div >> 1;
						skip      <= held_next;   // nobody took the old byte
						ovr_pulse <= held_next;
					end else if (take) begin
						state <= idle;
					end
				end
				start: begin
					if (tick) begin
						if (rxd_s) begin       // false start, glitch on line
							state <= held_next ? hold : idle;
							skip  <= 1'b0;
						end else begin
							state   <= data;
							bit_idx <= '0;
							par_acc <= 1'b0;
						end
					end
				end
				data: begin
					if (tick) begin
						par_acc <= par_acc ^ rxd_s;
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == 3'd7)
							state <= parity;
					end
				end
				parity: begin
					if (tick) begin
						par_bad <= par_acc ^ rxd_s;   // even parity, total ones even
						state   <= stop;
					end
				end
				stop: begin
					if (tick) begin
						skip <= 1'b0;
						if (skip) begin
							state <= held_next ? hold : idle;   // dropped frame
						end else if (par_bad || !rxd_s) begin
							state      <= idle;
							rx_err     <= 1'b1;
							perr_pulse <= par_bad;
							ferr_pulse <= ~rxd_s;   // stop bit low
						end else begin
							state      <= hold;
							byte_valid <= 1'b1;
						end
					end
				end
				default: state <= idle;
			endcase
		end
	end

	// data shift and output byte, LSB arrives first
	always_ff @(posedge dec_CLK) begin
		if ((state == data) && tick)
			shreg <= {rxd_s, shreg[7:1]};
		if (frame_ok)
			byte_data <= shreg;
	end

endmodule

`default_nettype wire

//--- verilog/word_assembler.sv
`timescale 1ns/1ps
`default_nettype none

// packs four bytes into a word, first byte lowest
module word_assembler (
	input  logic              dec_CLK,
	input  logic              nrst,
	input  logic              byte_valid,
	input  loader_pkg::byte_t byte_data,
	output logic              byte_ready,
	input  logic              rx_err,
	output logic              word_valid,
	output loader_pkg::word_t word_data,
	input  logic              word_ready
);
	import loader_pkg::*;

	logic [1:0] byte_cnt;   // bytes collected, 0..3
	logic       byte_take;
	logic       word_take;

	// count never reaches four, the word goes pending instead
	assign byte_ready = ~word_valid;
	assign byte_take  = byte_valid & byte_ready;
	assign word_take  = word_valid & word_ready;

	// ==============================
	// byte count and word valid
	// ==============================
	always_ff @(posedge dec_CLK) begin
		if (nrst) begin
			byte_cnt   <= '0;
			word_valid <= 1'b0;
		end else begin
			if (word_take)
				word_valid <= 1'b0;
			if (rx_err && !word_valid) begin
				byte_cnt <= '0;   // throw away partial word
			end else if (byte_take) begin
				byte_cnt <= byte_cnt + 1'b1;   // wraps to 0 after fourth
				if (byte_cnt == 2'd3)
					word_valid <= 1'b1;
			end
		end
	end

	// shift right, new byte on top
	// after four shifts the first byte sits in [7:0]
	always_ff @(posedge dec_CLK) begin
		if (byte_take)
			word_data <= {byte_data, word_data[31:8]};
	end

endmodule

`default_nettype wire

//--- verilog/loader_regs.sv
`timescale 1ns/1ps
`default_nettype none

// config registers and saturating event counters
module loader_regs (
	input  logic                  dec_CLK,
	input  logic                  nrst,
	input  logic                  cfg_we,
	input  loader_pkg::reg_addr_t cfg_addr,
	input  loader_pkg::cfg_data_t cfg_wdata,
	output loader_pkg::cfg_data_t cfg_rdata,
	output loader_pkg::div_t      div,
	output loader_pkg::addr_t     base,
	output logic                  base_load,
	input  logic                  perr_pulse,
	input  logic                  ferr_pulse,
	input  logic                  ovr_pulse,
	input  logic                  wr_pulse
);
	import loader_pkg::*;

	cnt_t perr_cnt;
	cnt_t ferr_cnt;
	cnt_t ovr_cnt;
	cnt_t words_cnt;

	// stick at all ones
	function automatic cnt_t sat_inc(input cnt_t v, input logic ev);
		sat_inc = (ev && (v != '1)) ? v + 1'b1 : v;
	endfunction

	// ==============================
	// host writes
	// ==============================
	always_ff @(posedge dec_CLK) begin
		if (nrst) begin
			div       <= div_reset;
			base      <= '0;
			base_load <= 1'b0;
		end else begin
			// one cycle late so the pointer sees the new base
			base_load <= cfg_we && (cfg_addr == reg_base);
			if (cfg_we) begin
				case (cfg_addr)
					reg_div:  div  <= div_t'(cfg_wdata);
					reg_base: base <= cfg_wdata[$bits(addr_t)-1:0];
					default:  ;   // counters are read only
				endcase
			end
		end
	end

	// event counters
	always_ff @(posedge dec_CLK) begin
		if (nrst) begin
			perr_cnt  <= '0;
			ferr_cnt  <= '0;
			ovr_cnt   <= '0;
			words_cnt <= '0;
		end else begin
			perr_cnt  <= sat_inc(perr_cnt, perr_pulse);
			ferr_cnt  <= sat_inc(ferr_cnt, ferr_pulse);
			ovr_cnt   <= sat_inc(ovr_cnt, ovr_pulse);
			words_cnt <= sat_inc(words_cnt, wr_pulse);
		end
	end

	// read mux, comb from address
	always_comb begin
		case (cfg_addr)
			reg_div:   cfg_rdata = cfg_data_t'(div);
			reg_base:  cfg_rdata = cfg_data_t'(base);   // zero extended
			reg_perr:  cfg_rdata = cfg_data_t'(perr_cnt);
			reg_ferr:  cfg_rdata = cfg_data_t'(ferr_cnt);
			reg_ovr:   cfg_rdata = cfg_data_t'(ovr_cnt);
			reg_words: cfg_rdata = cfg_data_t'(words_cnt);
			default:   cfg_rdata = '0;   // holes read zero
		endcase
	end

endmodule

`default_nettype wire

//--- verilog/load_ram.sv
`timescale 1ns/1ps
`default_nettype none

// single port load memory, host read beats load write
module load_ram (
	input  logic              dec_CLK,
	input  logic              nrst,
	input  logic              word_valid,
	input  loader_pkg::word_t word_data,
	output logic              word_ready,
	input  loader_pkg::addr_t base,
	input  logic              base_load,
	output logic              wr_pulse,
	input  logic              rd_en,
	input  loader_pkg::addr_t rd_addr,
	output loader_pkg::word_t rd_data,
	output logic              rd_valid
);
	import loader_pkg::*;

	word_t mem [mem_depth];
	addr_t wr_ptr;      // next load address
	logic  wr_take;

	// port busy with a read, so load path stalls
	assign word_ready = ~rd_en;
	assign wr_take    = word_valid & word_ready;

	// ==============================
	// write pointer and status
	// ==============================
	always_ff @(posedge dec_CLK) begin
		if (nrst) begin
			wr_ptr   <= '0;
			wr_pulse <= 1'b0;
			rd_valid <= 1'b0;
		end else begin
			wr_pulse <= wr_take;   // seen one cycle after the write
			rd_valid <= rd_en;
			if (base_load)
				wr_ptr <= base;
			else if (wr_take)
				wr_ptr <= wr_ptr + 1'b1;   // 255 wraps to 0
		end
	end

	// the one port, read or write per cycle
	always_ff @(posedge dec_CLK) begin
		if (rd_en)
			rd_data <= mem[rd_addr];
		else if (word_valid)
			mem[wr_ptr] <= word_data;
	end

endmodule

`default_nettype wire

//--- verilog/uart_loader_top.sv
`timescale 1ns/1ps
`default_nettype none

// serial program loader, rx -> assembler -> ram, regs on the side
module uart_loader_top (
	input  logic                  dec_CLK,
	input  logic                  nrst,
	input  logic                  rxd,
	input  logic                  cfg_we,
	input  loader_pkg::reg_addr_t cfg_addr,
	input  loader_pkg::cfg_data_t cfg_wdata,
	output loader_pkg::cfg_data_t cfg_rdata,
	input  logic                  rd_en,
	input  loader_pkg::addr_t     rd_addr,
	output loader_pkg::word_t     rd_data,
	output logic                  rd_valid
);
	import loader_pkg::*;

	// ==============================
	// internal nets
	// ==============================
	logic  byte_valid;    // rx -> assembler
	byte_t byte_data;
	logic  byte_ready;
	logic  rx_err;
	logic  word_valid;    // assembler -> ram
	word_t word_data;
	logic  word_ready;
	logic  perr_pulse;    // events into regs
	logic  ferr_pulse;
	logic  ovr_pulse;
	logic  wr_pulse;
	div_t  div;           // config out of regs
	addr_t base;
	logic  base_load;

	uart_rx uart_rx_inst (
		.dec_CLK    (dec_CLK),
		.nrst       (nrst),
		.rxd        (rxd),
		.div        (div),
		.byte_valid (byte_valid),
		.byte_data  (byte_data),
		.byte_ready (byte_ready),
		.rx_err     (rx_err),
		.perr_pulse (perr_pulse),
		.ferr_pulse (ferr_pulse),
		.ovr_pulse  (ovr_pulse)
	);

	word_assembler word_assembler_inst (
		.dec_CLK    (dec_CLK),
		.nrst       (nrst),
		.byte_valid (byte_valid),
		.byte_data  (byte_data),
		.byte_ready (byte_ready),
		.rx_err     (rx_err),
		.word_valid (word_valid),
		.word_data  (word_data),
		.word_ready (word_ready)
	);

	loader_regs loader_regs_inst (
		.dec_CLK    (dec_CLK),
		.nrst       (nrst),
		.cfg_we     (cfg_we),
		.cfg_addr   (cfg_addr),
		.cfg_wdata  (cfg_wdata),
		.cfg_rdata  (cfg_rdata),
		.div        (div),
		.base       (base),
		.base_load  (base_load),
		.perr_pulse (perr_pulse),
		.ferr_pulse (ferr_pulse),
		.ovr_pulse  (ovr_pulse),
		.wr_pulse   (wr_pulse)
	);

	load_ram load_ram_inst (
		.dec_CLK    (dec_CLK),
		.nrst       (nrst),
		.word_valid (word_valid),
		.word_data  (word_data),
		.word_ready (word_ready),
		.base       (base),
		.base_load  (base_load),
		.wr_pulse   (wr_pulse),
		.rd_en      (rd_en),
		.rd_addr    (rd_addr),
		.rd_data    (rd_data),
		.rd_valid   (rd_valid)
	);

endmodule

`default_nettype wire

//--- sim/tb_uart_loader.sv
`timescale 1ns/1ps
`default_nettype none

module tb_uart_loader;
	import loader_pkg::*;

	localparam div_t test_div = 16'd3;   // 4 clocks per bit

	logic      dec_CLK = 1'b0;
	logic      nrst;
	logic      rxd;
	logic      cfg_we;
	reg_addr_t cfg_addr;
	cfg_data_t cfg_wdata;
	cfg_data_t cfg_rdata;
	logic      rd_en;
	addr_t     rd_addr;
	word_t     rd_data;
	logic      rd_valid;

	// frame table with one entry per serial byte
	byte_t t_byte [$];
	bit    t_par [$];      // flip parity bit
	bit    t_stop [$];     // send stop bit low
	bit    t_wr [$];       // row finishes a word
	word_t t_word [$];     // word expected at that address
	int    row_idx;
	bit    rows_loaded = 1'b0;

	addr_t exp_addr;       // where the next word should land
	int    exp_words;
	addr_t chk_addr [$];   // words still to read back
	word_t chk_word [$];
	int    mism_cnt;
	int    fail_cnt;
	bit    reads_on;
	int    seed_val;

	always #20 dec_CLK = ~dec_CLK;

	uart_loader_top uart_loader_top_inst (
		.dec_CLK   (dec_CLK),
		.nrst      (nrst),
		.rxd       (rxd),
		.cfg_we    (cfg_we),
		.cfg_addr  (cfg_addr),
		.cfg_wdata (cfg_wdata),
		.cfg_rdata (cfg_rdata),
		.rd_en     (rd_en),
		.rd_addr   (rd_addr),
		.rd_data   (rd_data),
		.rd_valid  (rd_valid)
	);

	// ==============================
	// compare tasks
	// ==============================
	task automatic check_word(input string what, input word_t got, input word_t exp);
		if (got !== exp) begin
			$display("Mismatch %s: got 0x%h expected 0x%h at %0t", what, got, exp, $time);
			mism_cnt++;
		end
	endtask

	task automatic check_cfg(input string what, input cfg_data_t got, input cfg_data_t exp);
		if (got !== exp) begin
			$display("Mismatch %s: got 0x%h expected 0x%h at %0t", what, got, exp, $time);
			mism_cnt++;
		end
	endtask

	task automatic check_count(input string what, input cnt_t got, input cnt_t exp);
		if (got !== exp) begin
			$display("Mismatch %s: got 0x%h expected 0x%h at %0t", what, got, exp, $time);
			mism_cnt++;
		end
	endtask

	// ==============================
	// host and line drivers
	// ==============================
	task automatic add_row(input byte_t b, input bit p, input bit s, input bit w,
			input word_t e);
		t_byte.push_back(b);
		t_par.push_back(p);
		t_stop.push_back(s);
		t_wr.push_back(w);
		t_word.push_back(e);
	endtask

	task automatic write_cfg(input reg_addr_t a, input cfg_data_t d);
		cfg_we    = 1'b1;
		cfg_addr  = a;
		cfg_wdata = d;
		@(posedge dec_CLK);
		#2;
		cfg_we = 1'b0;
	endtask

	// rdata is comb from the address, sampled one edge later
	task automatic read_cfg(input reg_addr_t a, output cfg_data_t d);
		cfg_addr = a;
		@(posedge dec_CLK);
		#2;
		d = cfg_rdata;
	endtask

	task automatic read_mem(input addr_t a, output word_t d);
		rd_en   = 1'b1;
		rd_addr = a;
		@(posedge dec_CLK);
		#2;
		rd_en = 1'b0;
		if (rd_valid !== 1'b1) begin
			$display("rd_valid did not follow rd_en for address 0x%h", a);
			fail_cnt++;
		end
		d = rd_data;
	endtask

	// start, 8 data LSB first, even parity, stop
	task automatic send_frame(input byte_t b, input bit bad_par, input bit bad_stop);
		logic [10:0] bits;
		int i;
		bits = {~bad_stop, (^b) ^ bad_par, b, 1'b0};
		for (i = 0; i < 11; i++) begin
			rxd = bits[i];
			repeat (int'(test_div) + 1) @(posedge dec_CLK);
			#2;
		end
		rxd = 1'b1;
	endtask

	// next n table rows onto the line
	task automatic run_rows(input int n);
		int k;
		int gap;
		for (k = 0; k < n; k++) begin
			send_frame(t_byte[row_idx], t_par[row_idx], t_stop[row_idx]);
			if (t_wr[row_idx]) begin
				chk_addr.push_back(exp_addr);
				chk_word.push_back(t_word[row_idx]);
				exp_addr++;   // 8 bit wrap like the pointer
				exp_words++;
			end
			gap = 2 + ($urandom % 6);
			if (t_stop[row_idx])
				gap += int'(test_div) + 1;   // let a low stop bit clear the sync
			repeat (gap) @(posedge dec_CLK);
			#2;
			row_idx++;
		end
	endtask

	// poll reg_words until the last write shows up
	task automatic wait_words(input int n);
		cfg_data_t v;
		int cyc;
		cyc = 0;
		read_cfg(reg_words, v);
		while ((int'(v) != n) && (cyc < 200)) begin
			read_cfg(reg_words, v);
			cyc++;
		end
		if (int'(v) != n) begin
			$display("word count stuck at %0d while %0d words were expected", v, n);
			fail_cnt++;
		end
	endtask

	task automatic verify_pending();
		word_t got;
		addr_t a;
		wait_words(exp_words);
		while (chk_addr.size() > 0) begin
			a = chk_addr.pop_front();
			read_mem(a, got);
			check_word($sformatf("rd_data[0x%h]", a), got, chk_word.pop_front());
		end
	endtask

	task automatic check_reg(input string what, input reg_addr_t a, input cfg_data_t exp);
		cfg_data_t v;
		read_cfg(a, v);
		check_cfg(what, v, exp);
	endtask

	task automatic check_counter(input string what, input reg_addr_t a, input cnt_t exp);
		cfg_data_t v;
		read_cfg(a, v);
		check_count(what, cnt_t'(v), exp);
	endtask

	// ==============================
	// watchdog
	// ==============================
	initial begin
		longint wd_ns;
		wait (rows_loaded);
		wd_ns = longint'(t_byte.size()) * 11 * (longint'(test_div) + 1) * 40 * 2 + 4 * 40;
		#(wd_ns);
		$display("watchdog fired after %0d ns, the run is stuck", wd_ns);
		$display("test failed");
		$finish;
	end

	// ==============================
	// main sequence
	// ==============================
	initial begin
		nrst      = 1'b1;
		rxd       = 1'b1;   // line idle
		cfg_we    = 1'b0;
		cfg_addr  = '0;
		cfg_wdata = '0;
		rd_en     = 1'b0;
		rd_addr   = '0;
		mism_cnt  = 0;
		fail_cnt  = 0;
		row_idx   = 0;
		exp_words = 0;
		reads_on  = 1'b0;
		seed_val  = 32'h78f56e4b;
		void'($urandom(seed_val));

		// byte, bad parity, bad stop, ends word, expected word
		add_row(8'hfa, 0, 0, 0, '0);   // basic word at 0x10
		add_row(8'hde, 0, 0, 0, '0);
		add_row(8'hda, 0, 0, 0, '0);
		add_row(8'he1, 0, 0, 1, 32'he1dadefa);
		add_row(8'h11, 0, 0, 0, '0);   // parity error mid word
		add_row(8'h22, 0, 0, 0, '0);
		add_row(8'h33, 1, 0, 0, '0);
		add_row(8'h44, 0, 0, 0, '0);
		add_row(8'h55, 0, 0, 0, '0);
		add_row(8'h66, 0, 0, 0, '0);
		add_row(8'h77, 0, 0, 1, 32'h77665544);
		add_row(8'h88, 0, 0, 0, '0);   // framing error
		add_row(8'h99, 0, 1, 0, '0);
		add_row(8'ha1, 0, 0, 0, '0);
		add_row(8'hb2, 0, 0, 0, '0);
		add_row(8'hc3, 0, 0, 0, '0);
		add_row(8'hd4, 0, 0, 1, 32'hd4c3b2a1);
		add_row(8'h01, 0, 0, 0, '0);   // under host reads
		add_row(8'h23, 0, 0, 0, '0);
		add_row(8'h45, 0, 0, 0, '0);
		add_row(8'h67, 0, 0, 1, 32'h67452301);
		add_row(8'h89, 0, 0, 0, '0);
		add_row(8'hab, 0, 0, 0, '0);
		add_row(8'hcd, 0, 0, 0, '0);
		add_row(8'hef, 0, 0, 1, 32'hefcdab89);
		add_row(8'h5a, 0, 0, 0, '0);   // new base 0xfe with wrap to 0
		add_row(8'ha5, 0, 0, 0, '0);
		add_row(8'h3c, 0, 0, 0, '0);
		add_row(8'hc3, 0, 0, 1, 32'hc33ca55a);
		add_row(8'h0f, 0, 0, 0, '0);
		add_row(8'hf0, 0, 0, 0, '0);
		add_row(8'h96, 0, 0, 0, '0);
		add_row(8'h69, 0, 0, 1, 32'h6996f00f);
		add_row(8'h12, 0, 0, 0, '0);
		add_row(8'h34, 0, 0, 0, '0);
		add_row(8'h56, 0, 0, 0, '0);
		add_row(8'h78, 0, 0, 1, 32'h78563412);
		rows_loaded = 1'b1;

		repeat (4) @(posedge dec_CLK);
		#2;
		nrst = 1'b0;

		// register defaults and readback
		check_reg("cfg_rdata div", reg_div, 16'd15);
		check_reg("cfg_rdata base", reg_base, 16'h0000);
		check_counter("cfg_rdata perr", reg_perr, 16'd0);
		check_counter("cfg_rdata ferr", reg_ferr, 16'd0);
		check_counter("cfg_rdata ovr", reg_ovr, 16'd0);
		check_counter("cfg_rdata words", reg_words, 16'd0);
		check_reg("cfg_rdata hole", 3'd6, 16'h0000);
		write_cfg(reg_div, cfg_data_t'(test_div));
		write_cfg(reg_base, 16'h0010);
		check_reg("cfg_rdata div", reg_div, cfg_data_t'(test_div));
		check_reg("cfg_rdata base", reg_base, 16'h0010);
		exp_addr = 8'h10;

		run_rows(4);
		verify_pending();
		check_counter("cfg_rdata words", reg_words, 16'd1);

		run_rows(7);   // bad parity in the middle
		verify_pending();
		check_counter("cfg_rdata perr", reg_perr, 16'd1);

		run_rows(6);   // low stop bit
		verify_pending();
		check_counter("cfg_rdata ferr", reg_ferr, 16'd1);

		// reads every other cycle steal the port
		reads_on = 1'b1;
		fork
			begin
				run_rows(8);
				reads_on = 1'b0;
			end
			begin
				while (reads_on) begin
					rd_en   = 1'b1;
					rd_addr = addr_t'($urandom % 256);
					@(posedge dec_CLK);
					#2;
					rd_en = 1'b0;
					if (rd_valid !== 1'b1) begin
						$display("rd_valid missing after a background read");
						fail_cnt++;
					end
					@(posedge dec_CLK);
					#2;
					if (rd_valid !== 1'b0) begin
						$display("rd_valid stayed high in a cycle without a read");
						fail_cnt++;
					end
				end
			end
		join
		verify_pending();

		// restart at 0xfe so the third word wraps to 0
		write_cfg(reg_base, 16'h00fe);
		check_reg("cfg_rdata base", reg_base, 16'h00fe);
		exp_addr = 8'hfe;
		run_rows(12);
		verify_pending();

		check_counter("cfg_rdata perr", reg_perr, 16'd1);
		check_counter("cfg_rdata ferr", reg_ferr, 16'd1);
		check_counter("cfg_rdata ovr", reg_ovr, 16'd0);
		check_counter("cfg_rdata words", reg_words, cnt_t'(exp_words));

		$display("run finished: %0d mismatches, %0d other errors", mism_cnt, fail_cnt);
		if ((mism_cnt == 0) && (fail_cnt == 0))
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- sim.f
verilog/loader_pkg.sv
verilog/uart_rx.sv
verilog/word_assembler.sv
verilog/loader_regs.sv
verilog/load_ram.sv
verilog/uart_loader_top.sv
sim/tb_uart_loader.sv
